// File: alu_lane.sv
`timescale 1ns/1ps

module alu_lane
    import exu_cfg_pkg::*;
    import exu_op_pkg::*;
(
    input  logic        clock,
    input  logic        rst_n,
    input  logic        flush_valid,
    input  robid_t      flush_robid,
    lane_issue_if.lane  issue,
    lane_result_if.lane res
);

    lane_state_t state;
    mul_cnt_t    cnt;
    logic        kill;
    logic        kill_new;
    logic        accept;
    data_t       mul_res;

    robid_t      robid_q;
    preg_t       prd_q;
    logic        need_to_wb_q;
    data_t       opa_q;
    data_t       opb_q;
    logic        is_word_q;
    data_t       result_q;

    function automatic data_t sext32(data_t d);
        return {{(xlen - 32){d[31]}}, d[31:0]};
    endfunction

    // Distance modulo the ROB size, 1 to half the ROB means younger
    function automatic logic is_younger(robid_t id, robid_t f);
        robid_t diff;
        diff = id - f;
        return (diff != '0) && !diff[robid_width-1];
    endfunction

    function automatic data_t alu_calc(alu_op_t f_op, data_t a, data_t b, logic word);
        data_t      a_ext;
        data_t      b_ext;
        logic [5:0] shamt;
        data_t      r;
        a_ext = a;
        b_ext = b;
        shamt = word ? {1'b0, b[4:0]} : b[5:0];
        if (word) begin
            // srlw shifts in zeros from bit 31
            a_ext = (f_op == op_srl) ? {{(xlen - 32){1'b0}}, a[31:0]} : sext32(a);
            b_ext = sext32(b);
        end
        case (f_op)
            op_add:  r = a_ext + b_ext;
            op_sub:  r = a_ext - b_ext;
            op_and:  r = a_ext & b_ext;
            op_or:   r = a_ext | b_ext;
            op_xor:  r = a_ext ^ b_ext;
            op_sll:  r = a_ext << shamt;
            op_srl:  r = a_ext >> shamt;
            op_slt:  r = data_t'($signed(a_ext) < $signed(b_ext));
            default: r = '0;
        endcase
        return word ? sext32(r) : r;
    endfunction

    assign accept   = (state == lane_idle) && issue.valid;
    assign kill     = flush_valid && is_younger(robid_q, flush_robid);
    assign kill_new = flush_valid && is_younger(issue.robid, flush_robid);

    // Operands held since issue, so the product has the busy cycles to settle
    assign mul_res = is_word_q ? sext32(opa_q * opb_q) : opa_q * opb_q;

    assign issue.free     = (state == lane_idle);
    assign res.done       = (state == lane_done) && !kill;
    assign res.robid      = robid_q;
    assign res.prd        = prd_q;
    assign res.result     = result_q;
    assign res.need_to_wb = need_to_wb_q;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= lane_idle;
            cnt   <= '0;
        end else begin
            case (state)
                lane_idle: begin
                    if (accept && !kill_new) begin
                        state <= (issue.op == op_mul) ? lane_busy : lane_done;
                        cnt   <= mul_cnt_t'(mul_cycles - 2);
                    end
                end
                lane_busy: begin
                    if (kill) begin
                        state <= lane_idle;
                    end else if (cnt == '0) begin
                        state <= lane_done;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                lane_done: begin
                    if (kill || res.grant) begin
                        state <= lane_idle;
                    end
                end
                default: state <= lane_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            robid_q      <= issue.robid;
            prd_q        <= issue.prd;
            need_to_wb_q <= issue.need_to_wb;
            opa_q        <= issue.opa;
            opb_q        <= issue.opb;
            is_word_q    <= issue.is_word;
            result_q     <= alu_calc(issue.op, issue.opa, issue.opb, issue.is_word);
        end else if (state == lane_busy && cnt == '0) begin
            result_q <= mul_res;
        end
    end

endmodule

// File: exu_cfg_pkg.sv
package exu_cfg_pkg;

    // Datapath and tag sizes
    localparam int xlen        = 64;
    localparam int robid_width = 6;
    localparam int preg_width  = 7;

    // Number of execution lanes behind the dispatcher
    localparam int num_lanes      = 2;
    localparam int lane_sel_width = 1;

    // Multiply latency in execute cycles
    localparam int mul_cycles    = 3;
    localparam int mul_cnt_width = $clog2(mul_cycles);

    typedef logic [xlen-1:0]           data_t;
    typedef logic [robid_width-1:0]    robid_t;
    typedef logic [preg_width-1:0]     preg_t;
    typedef logic [lane_sel_width-1:0] lane_sel_t;
    typedef logic [mul_cnt_width-1:0]  mul_cnt_t;

endpackage

// File: exu_dispatch.sv
`timescale 1ns/1ps

module exu_dispatch
    import exu_cfg_pkg::*;
    import exu_op_pkg::*;
(
    input  logic          clock,
    input  logic          rst_n,
    input  logic          instr_valid,
    output logic          instr_ready,
    input  robid_t        robid,
    input  preg_t         prd,
    input  data_t         src1,
    input  data_t         src2,
    input  data_t         imm,
    input  logic          is_imm,
    input  alu_op_t       op,
    input  logic          is_word,
    input  logic          need_to_wb,
    lane_issue_if.dispatch lanes [num_lanes]
);

    logic [num_lanes-1:0] free_vec;
    logic [num_lanes-1:0] pend_vec;
    logic [num_lanes-1:0] avail;
    lane_sel_t            ptr;
    lane_sel_t            sel;
    logic                 fire;

    // Issue register, one op in flight to its lane
    logic                 valid_q;
    lane_sel_t            sel_q;
    robid_t               robid_q;
    preg_t                prd_q;
    data_t                opa_q;
    data_t                opb_q;
    alu_op_t              op_q;
    logic                 is_word_q;
    logic                 need_to_wb_q;

    for (genvar g = 0; g < num_lanes; g++) begin : g_lane
        assign free_vec[g]        = lanes[g].free;
        assign pend_vec[g]        = valid_q && (sel_q == lane_sel_t'(g));
        assign lanes[g].valid      = pend_vec[g];
        assign lanes[g].robid      = robid_q;
        assign lanes[g].prd        = prd_q;
        assign lanes[g].opa        = opa_q;
        assign lanes[g].opb        = opb_q;
        assign lanes[g].op         = op_q;
        assign lanes[g].is_word    = is_word_q;
        assign lanes[g].need_to_wb = need_to_wb_q;
    end

    // A lane with a pending strobe is taken even though still idle
    assign avail       = free_vec & ~pend_vec;
    assign instr_ready = |avail;
    assign fire        = instr_valid && instr_ready;

    // First available lane at or after the pointer
    always_comb begin
        int idx;
        logic found;
        sel   = ptr;
        found = 1'b0;
        for (int i = 0; i < num_lanes; i++) begin
            idx = (int'(ptr) + i) % num_lanes;
            if (!found && avail[idx]) begin
                sel   = lane_sel_t'(idx);
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            ptr     <= '0;
        end else begin
            valid_q <= fire;
            if (fire) begin
                ptr <= (sel == lane_sel_t'(num_lanes - 1)) ? '0 : sel + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (fire) begin
            sel_q        <= sel;
            robid_q      <= robid;
            prd_q        <= prd;
            opa_q        <= src1;
            opb_q        <= is_imm ? imm : src2;
            op_q         <= op;
            is_word_q    <= is_word;
            need_to_wb_q <= need_to_wb;
        end
    end

endmodule

// File: exu_lane_if.sv
`timescale 1ns/1ps

// Dispatcher to lane, one op per valid strobe
interface lane_issue_if import exu_cfg_pkg::*, exu_op_pkg::*; ();

    logic    valid;
    logic    free;
    robid_t  robid;
    preg_t   prd;
    data_t   opa;
    data_t   opb;
    alu_op_t op;
    logic    is_word;
    logic    need_to_wb;

    modport dispatch (
        output valid, robid, prd, opa, opb, op, is_word, need_to_wb,
        input  free
    );

    modport lane (
        input  valid, robid, prd, opa, opb, op, is_word, need_to_wb,
        output free
    );

endinterface

// Lane to writeback, done held until granted
interface lane_result_if import exu_cfg_pkg::*, exu_op_pkg::*; ();

    logic   done;
    logic   grant;
    robid_t robid;
    preg_t  prd;
    data_t  result;
    logic   need_to_wb;

    modport lane (
        output done, robid, prd, result, need_to_wb,
        input  grant
    );

    modport writeback (
        input  done, robid, prd, result, need_to_wb,
        output grant
    );

endinterface

// File: exu_op_pkg.sv
package exu_op_pkg;

    typedef logic [3:0] alu_op_t;

    // Operation codes
    localparam alu_op_t op_add = 4'd0;
    localparam alu_op_t op_sub = 4'd1;
    localparam alu_op_t op_and = 4'd2;
    localparam alu_op_t op_or  = 4'd3;
    localparam alu_op_t op_xor = 4'd4;
    localparam alu_op_t op_sll = 4'd5;
    localparam alu_op_t op_srl = 4'd6;
    localparam alu_op_t op_slt = 4'd7;
    localparam alu_op_t op_mul = 4'd8;

    // Lane FSM
    typedef enum logic [1:0] {
        lane_idle,
        lane_busy,
        lane_done
    } lane_state_t;

endpackage

// File: exu_top.sv
`timescale 1ns/1ps

module exu_top
    import exu_cfg_pkg::*;
    import exu_op_pkg::*;
(
    input  logic    clock,
    input  logic    rst_n,

    // Issue
    input  logic    instr_valid,
    output logic    instr_ready,
    input  robid_t  robid,
    input  preg_t   prd,
    input  data_t   src1,
    input  data_t   src2,
    input  data_t   imm,
    input  logic    is_imm,
    input  alu_op_t op,
    input  logic    is_word,
    input  logic    need_to_wb,

    // Flush
    input  logic    flush_valid,
    input  robid_t  flush_robid,

    // Writeback
    output logic    wb_valid,
    output robid_t  wb_robid,
    output preg_t   wb_prd,
    output logic    wb_need_to_wb,
    output data_t   wb_result
);

    lane_issue_if  issue_bus  [num_lanes] ();
    lane_result_if result_bus [num_lanes] ();

    exu_dispatch u_dispatch (
        .clock       (clock),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .robid       (robid),
        .prd         (prd),
        .src1        (src1),
        .src2        (src2),
        .imm         (imm),
        .is_imm      (is_imm),
        .op          (op),
        .is_word     (is_word),
        .need_to_wb  (need_to_wb),
        .lanes       (issue_bus)
    );

    for (genvar g = 0; g < num_lanes; g++) begin : g_lane
        alu_lane u_lane (
            .clock       (clock),
            .rst_n       (rst_n),
            .flush_valid (flush_valid),
            .flush_robid (flush_robid),
            .issue       (issue_bus[g]),
            .res         (result_bus[g])
        );
    end

    exu_writeback u_writeback (
        .clock         (clock),
        .rst_n         (rst_n),
        .lanes         (result_bus),
        .wb_valid      (wb_valid),
        .wb_robid      (wb_robid),
        .wb_prd        (wb_prd),
        .wb_need_to_wb (wb_need_to_wb),
        .wb_result     (wb_result)
    );

endmodule

// File: exu_vectors.txt
// kind robid prd src1 src2 imm is_imm op is_word need_to_wb expected, all hex
// kind 1 issue, 2 flush with the ROB id in column two, 3 wait with the cycles there
1 01 11 0000000000001234 0000000000000ff0 0000000000000000 0 0 0 1 0000000000002224
1 02 12 7fffffffffffffff 0000000000005555 0000000000000001 1 0 0 1 8000000000000000
1 03 13 0000000000000010 0000000000000020 0000000000000000 0 1 0 1 fffffffffffffff0
1 04 14 f0f0f0f0f0f0f0f0 0000000000000000 00000000ffff0000 1 2 0 1 00000000f0f00000
1 05 15 0f00000000000000 00000000000000ff 0000000000000000 0 3 0 0 0f000000000000ff
1 06 16 aaaaaaaaaaaaaaaa 0000000000000000 ffffffffffffffff 1 4 0 1 5555555555555555
// Shift amount 44 keeps only its low 6 bits
1 07 17 0000000000000003 0000000000000044 0000000000000000 0 5 0 1 0000000000000030
1 08 18 8000000000000000 0000000000000000 000000000000003f 1 6 0 1 0000000000000001
1 09 19 ffffffffffffffff 0000000000000001 0000000000000000 0 7 0 1 0000000000000001
1 0a 1a 0000000000000005 0000000000000000 fffffffffffffffb 1 7 0 0 0000000000000000
1 0b 1b 0000000100000000 0000000100000003 0000000000000000 0 8 0 1 0000000300000000
// Word forms
1 0c 1c 000000007fffffff 0000000000000001 0000000000000000 0 0 1 1 ffffffff80000000
1 0d 1d 1234567800000000 0000000000000000 0000000000000001 1 1 1 1 ffffffffffffffff
1 0e 1e 0000000000000001 000000000000003f 0000000000000000 0 5 1 1 ffffffff80000000
1 0f 1f ffffffff80000000 0000000000000000 0000000000000024 1 6 1 0 0000000008000000
1 10 20 0000000000010000 0000000000008000 0000000000000000 0 8 1 1 ffffffff80000000
// Multiplies between ALU ops, results leave out of order
1 11 21 0000000000000007 0000000000000006 0000000000000000 0 8 0 1 000000000000002a
1 12 22 0000000000000001 0000000000000002 0000000000000000 0 0 0 1 0000000000000003
1 13 23 ffffffffffffffff 0000000000000009 0000000000000005 1 8 0 1 fffffffffffffffb
1 14 24 00000000000000ff 000000000000000f 0000000000000000 0 4 0 0 00000000000000f0
1 15 25 0000000012345678 0000000000000010 0000000000000000 0 8 0 1 0000000123456780
3 c 0 0 0 0 0 0 0 0 0
// Flush by 20 keeps 20 and kills 21
1 20 30 0000000000000003 0000000000000003 0000000000000000 0 8 0 1 0000000000000009
1 21 31 0000000000000004 0000000000000004 0000000000000000 0 8 0 1 0000000000000010
2 20 0 0 0 0 0 0 0 0 0
3 a 0 0 0 0 0 0 0 0 0
// Wrap around, 3f and 00 are younger than 3e while 30 is older
1 30 32 0000000000000100 0000000000000001 0000000000000000 0 0 0 1 0000000000000101
1 3f 33 0000000000000002 0000000000000003 0000000000000000 0 8 0 1 0000000000000006
1 00 34 0000000000000005 0000000000000005 0000000000000000 0 8 0 1 0000000000000019
2 3e 0 0 0 0 0 0 0 0 0
3 a 0 0 0 0 0 0 0 0 0
// 25 leaves before the flush by 24, 23 is older, 26 is killed
1 25 35 000000000000000a 000000000000000b 0000000000000000 0 0 0 1 0000000000000015
3 6 0 0 0 0 0 0 0 0 0
1 23 36 0000000000000020 0000000000000001 0000000000000000 0 0 0 0 0000000000000021
1 26 37 0000000000000006 0000000000000007 0000000000000000 0 8 0 1 000000000000002a
2 24 0 0 0 0 0 0 0 0 0
3 a 0 0 0 0 0 0 0 0 0

// File: exu_writeback.sv
`timescale 1ns/1ps

module exu_writeback
    import exu_cfg_pkg::*;
    import exu_op_pkg::*;
(
    input  logic                    clock,
    input  logic                    rst_n,
    lane_result_if.writeback        lanes [num_lanes],
    output logic                    wb_valid,
    output robid_t                  wb_robid,
    output preg_t                   wb_prd,
    output logic                    wb_need_to_wb,
    output data_t                   wb_result
);

    logic [num_lanes-1:0] done_vec;
    logic [num_lanes-1:0] grant_vec;
    robid_t               lane_robid  [num_lanes];
    preg_t                lane_prd    [num_lanes];
    data_t                lane_result [num_lanes];
    logic                 lane_wb     [num_lanes];
    lane_sel_t            rr_ptr;
    lane_sel_t            win;
    logic                 any;

    for (genvar g = 0; g < num_lanes; g++) begin : g_lane
        assign done_vec[g]    = lanes[g].done;
        assign lane_robid[g]  = lanes[g].robid;
        assign lane_prd[g]    = lanes[g].prd;
        assign lane_result[g] = lanes[g].result;
        assign lane_wb[g]     = lanes[g].need_to_wb;
        assign lanes[g].grant = grant_vec[g];
    end

    // Round robin, search starts one past the last winner
    always_comb begin
        int idx;
        win = rr_ptr;
        any = 1'b0;
        for (int i = 0; i < num_lanes; i++) begin
            idx = (int'(rr_ptr) + i) % num_lanes;
            if (!any && done_vec[idx]) begin
                win = lane_sel_t'(idx);
                any = 1'b1;
            end
        end
        grant_vec      = '0;
        grant_vec[win] = any;
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            rr_ptr   <= '0;
        end else begin
            wb_valid <= any;
            if (any) begin
                rr_ptr <= (win == lane_sel_t'(num_lanes - 1)) ? '0 : win + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (any) begin
            wb_robid      <= lane_robid[win];
            wb_prd        <= lane_prd[win];
            wb_need_to_wb <= lane_wb[win];
            wb_result     <= lane_result[win];
        end
    end

endmodule

// File: filelist.f
exu_cfg_pkg.sv
exu_op_pkg.sv
exu_lane_if.sv
exu_dispatch.sv
alu_lane.sv
exu_writeback.sv
exu_top.sv
tb_clock_gen.sv
tb_exu_top.sv

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // Reset held over four rising edges, released between edges
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
    end

endmodule

// File: tb_exu_top.sv
`timescale 1ns/1ps

module tb_exu_top
    import exu_cfg_pkg::*;
    import exu_op_pkg::*;
();

    localparam int rec_words = 11;
    localparam int max_recs  = 64;
    localparam int num_ids   = 1 << robid_width;

    localparam logic [1:0] sb_none    = 2'd0;
    localparam logic [1:0] sb_pending = 2'd1;
    localparam logic [1:0] sb_written = 2'd2;
    localparam logic [1:0] sb_flushed = 2'd3;

    logic    clock;
    logic    rst_n;
    logic    instr_valid;
    logic    instr_ready;
    robid_t  robid;
    preg_t   prd;
    data_t   src1;
    data_t   src2;
    data_t   imm;
    logic    is_imm;
    alu_op_t op;
    logic    is_word;
    logic    need_to_wb;
    logic    flush_valid;
    robid_t  flush_robid;
    logic    wb_valid;
    robid_t  wb_robid;
    preg_t   wb_prd;
    logic    wb_need_to_wb;
    data_t   wb_result;

    logic [63:0] vec_mem [rec_words * max_recs];
    int          num_recs;
    logic        loaded;

    // Scoreboard indexed by ROB id
    logic [1:0]  sb_state  [num_ids];
    preg_t       sb_prd    [num_ids];
    logic        sb_nwb    [num_ids];
    data_t       sb_result [num_ids];

    int error_count;
    int issue_count;
    int wb_count;
    int flush_count;
    int ready_low_count;

    tb_clock_gen u_clock_gen (
        .clock (clock),
        .rst_n (rst_n)
    );

    exu_top u_dut (
        .clock         (clock),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .instr_ready   (instr_ready),
        .robid         (robid),
        .prd           (prd),
        .src1          (src1),
        .src2          (src2),
        .imm           (imm),
        .is_imm        (is_imm),
        .op            (op),
        .is_word       (is_word),
        .need_to_wb    (need_to_wb),
        .flush_valid   (flush_valid),
        .flush_robid   (flush_robid),
        .wb_valid      (wb_valid),
        .wb_robid      (wb_robid),
        .wb_prd        (wb_prd),
        .wb_need_to_wb (wb_need_to_wb),
        .wb_result     (wb_result)
    );

    // Younger when (id - f) mod 64 falls in 1..31
    function automatic logic younger_than(robid_t id, robid_t f);
        robid_t diff;
        diff = id - f;
        return (diff >= robid_t'(1)) && (diff <= robid_t'(31));
    endfunction

    function automatic int pending_count();
        int n;
        n = 0;
        for (int i = 0; i < num_ids; i++) begin
            if (sb_state[i] == sb_pending) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic print_counts();
        $display("issued %0d, written back %0d, flushed %0d, errors %0d",
                 issue_count, wb_count, flush_count, error_count);
    endtask

    task automatic drive_issue(input int base);
        robid_t id;
        logic   ready_seen;
        id          = robid_t'(vec_mem[base + 1]);
        instr_valid <= 1'b1;
        robid       <= id;
        prd         <= preg_t'(vec_mem[base + 2]);
        src1        <= vec_mem[base + 3];
        src2        <= vec_mem[base + 4];
        imm         <= vec_mem[base + 5];
        is_imm      <= vec_mem[base + 6][0];
        op          <= alu_op_t'(vec_mem[base + 7]);
        is_word     <= vec_mem[base + 8][0];
        need_to_wb  <= vec_mem[base + 9][0];
        // Held until instr_ready is seen ahead of an edge
        do begin
            @(negedge clock);
            ready_seen = instr_ready;
            if (!ready_seen) begin
                ready_low_count++;
            end
            @(posedge clock);
        end while (!ready_seen);
        instr_valid <= 1'b0;
        sb_state[id]  = sb_pending;
        sb_prd[id]    = preg_t'(vec_mem[base + 2]);
        sb_nwb[id]    = vec_mem[base + 9][0];
        sb_result[id] = vec_mem[base + 10];
        issue_count++;
    endtask

    task automatic drive_flush(input robid_t f);
        flush_valid <= 1'b1;
        flush_robid <= f;
        @(posedge clock);
        flush_valid <= 1'b0;
        // Younger ops still in flight are gone once this edge samples the flush
        for (int i = 0; i < num_ids; i++) begin
            if (sb_state[i] == sb_pending && younger_than(robid_t'(i), f)) begin
                sb_state[i] = sb_flushed;
                flush_count++;
            end
        end
    endtask

    task automatic check_writeback();
        int id;
        id = int'(wb_robid);
        wb_count++;
        assert (sb_state[id] == sb_pending) else begin
            error_count++;
            if (sb_state[id] == sb_flushed) begin
                $display("Flushed op with ROB id %h was written back", wb_robid);
            end else if (sb_state[id] == sb_written) begin
                $display("Op with ROB id %h was written back twice", wb_robid);
            end else begin
                $display("Writeback for ROB id %h that was never issued", wb_robid);
            end
        end
        if (sb_state[id] == sb_pending) begin
            assert (wb_prd == sb_prd[id]) else begin
                $display("[ERROR] wb_prd robid %h: got %h expected %h",
                         wb_robid, wb_prd, sb_prd[id]);
                error_count++;
            end
            assert (wb_need_to_wb == sb_nwb[id]) else begin
                $display("[ERROR] wb_need_to_wb robid %h: got %h expected %h",
                         wb_robid, wb_need_to_wb, sb_nwb[id]);
                error_count++;
            end
            assert (wb_result == sb_result[id]) else begin
                $display("[ERROR] wb_result robid %h: got %h expected %h",
                         wb_robid, wb_result, sb_result[id]);
                error_count++;
            end
            sb_state[id] = sb_written;
        end
    endtask

    // Writeback outputs are stable at the falling edge
    always @(negedge clock) begin
        if (rst_n && wb_valid) begin
            check_writeback();
        end
    end

    initial begin : driver
        int          base;
        int          drain;
        int unsigned rnd;
        instr_valid = 1'b0;
        robid       = '0;
        prd         = '0;
        src1        = '0;
        src2        = '0;
        imm         = '0;
        is_imm      = 1'b0;
        op          = op_add;
        is_word     = 1'b0;
        need_to_wb  = 1'b0;
        flush_valid = 1'b0;
        flush_robid = '0;
        rnd         = $urandom(60);

        for (int i = 0; i < num_ids; i++) begin
            sb_state[i] = sb_none;
        end
        for (int i = 0; i < rec_words * max_recs; i++) begin
            vec_mem[i] = '0;
        end
        $readmemh("exu_vectors.txt", vec_mem);
        num_recs = 0;
        while (num_recs < max_recs && vec_mem[num_recs * rec_words] != 0) begin
            num_recs++;
        end
        loaded = 1'b1;

        wait (rst_n === 1'b1);
        @(negedge clock);
        assert (instr_ready === 1'b1) else begin
            $display("[ERROR] instr_ready after reset: got %h expected 1", instr_ready);
            error_count++;
        end
        assert (wb_valid === 1'b0) else begin
            $display("[ERROR] wb_valid after reset: got %h expected 0", wb_valid);
            error_count++;
        end
        @(posedge clock);

        for (int r = 0; r < num_recs; r++) begin
            base = r * rec_words;
            case (vec_mem[base])
                64'd1: begin
                    drive_issue(base);
                    if (r + 1 < num_recs && vec_mem[base + rec_words] == 64'd1) begin
                        rnd = $urandom;
                        if (rnd % 4 == 0) begin
                            @(posedge clock);
                        end
                    end
                end
                64'd2:   drive_flush(robid_t'(vec_mem[base + 1]));
                64'd3:   repeat (int'(vec_mem[base + 1])) @(posedge clock);
                default: begin
                    $display("Unknown command in vector record %0d", r);
                    error_count++;
                end
            endcase
        end

        drain = 0;
        while (pending_count() > 0 && drain < 200) begin
            @(posedge clock);
            drain++;
        end
        // A few more cycles to catch late or killed results
        repeat (10) @(posedge clock);

        for (int i = 0; i < num_ids; i++) begin
            assert (sb_state[i] != sb_pending) else begin
                $display("ROB id %h was issued but never written back", robid_t'(i));
                error_count++;
            end
        end
        assert (ready_low_count > 0) else begin
            $display("instr_ready never went low while both lanes were busy");
            error_count++;
        end

        print_counts();
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        wait (loaded === 1'b1);
        limit = num_recs * 40 + 100;
        repeat (limit) @(posedge clock);
        $display("Timeout after %0d cycles, the run did not finish", limit);
        print_counts();
        $display("Simulation failed");
        $finish;
    end

endmodule
